//--- filelist.f
+incdir+source
source/icache_pkg.sv
source/icache_ctrl.sv
source/icache_mem.sv
source/icache_top.sv
verif/imem_model.sv
verif/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module icache_tb \
    -Mdir obj_dir \
    -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- source/icache_consts.svh
// icache geometry and bus constants
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch ports served per cycle, 1, 2 or 4
`define WAYS 2

// block geometry, one block per memory beat
`define BLOCK_BITS 64
`define BLOCK_BYTES 8
`define OFFSET_BITS 3

// direct mapped, 32 sets over a 16-bit fetch space
`define SET_BITS 5
`define TAG_BITS 8
`define SETS (1 << `SET_BITS)
`define TAG_LSB (`OFFSET_BITS + `SET_BITS)

// memory transaction tags, 0 means none
`define MEM_TAG_BITS 4
`define MEM_TAGS (1 << `MEM_TAG_BITS)

`define PREFETCH_DEPTH 4
`define MEM_LATENCY 6

`endif

//--- source/icache_ctrl.sv
// icache miss and prefetch controller
`include "icache_consts.svh"

module icache_ctrl import icache_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  fetch_req_t [`WAYS-1:0]   fetch,
    input  logic       [`WAYS-1:0]   hit,
    input  mem_rsp_t                 mem_rsp,
    output mem_req_t                 mem_req,
    output fill_t                    fill
);

    localparam int CNT_BITS = $clog2(`PREFETCH_DEPTH + 1);

    wait_entry_t [`MEM_TAGS-1:0] wait_q;
    wait_entry_t [`MEM_TAGS-1:0] wait_d;
    pend_entry_t [`SETS-1:0]     pend_q;
    pend_entry_t [`SETS-1:0]     pend_d;

    logic [CNT_BITS-1:0] prefetch_cnt;
    logic [CNT_BITS-1:0] prefetch_cnt_d;
    logic [31:0]         prefetch_addr;
    logic [31:0]         prefetch_addr_d;

    logic [`WAYS-1:0] miss;
    logic [`WAYS-1:0] pending_hit;
    logic [`WAYS-1:0] demand;          // miss that still needs a load
    logic             any_demand;
    logic [31:0]      fetch_addr;

    logic                 prefetch_active;
    logic                 prefetch_pending;
    logic [`SET_BITS-1:0] prefetch_idx;
    logic [`TAG_BITS-1:0] prefetch_tag;

    logic                 accepted;
    logic [`SET_BITS-1:0] req_idx;
    logic [`TAG_BITS-1:0] req_tag;

    for (genvar i = 0; i < `WAYS; i++) begin : g_port
        logic [`SET_BITS-1:0] idx;
        logic [`TAG_BITS-1:0] tag;

        assign idx = fetch[i].addr[`OFFSET_BITS +: `SET_BITS];
        assign tag = fetch[i].addr[`TAG_LSB +: `TAG_BITS];

        assign miss[i] = fetch[i].en && !hit[i];
        // block already on its way, no second load
        assign pending_hit[i] = fetch[i].en && pend_q[idx].valid && (pend_q[idx].tag == tag);
        assign demand[i] = miss[i] && !pending_hit[i];
    end

    // lowest numbered demand port wins the bus
    always_comb begin
        fetch_addr = '0;
        any_demand = 1'b0;
        for (int i = `WAYS - 1; i >= 0; i--) begin
            if (demand[i]) begin
                fetch_addr = {fetch[i].addr[31:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
                any_demand = 1'b1;
            end
        end
    end

    assign prefetch_active = (prefetch_cnt != '0);
    assign prefetch_idx = prefetch_addr[`OFFSET_BITS +: `SET_BITS];
    assign prefetch_tag = prefetch_addr[`TAG_LSB +: `TAG_BITS];
    assign prefetch_pending = pend_q[prefetch_idx].valid
                              && (pend_q[prefetch_idx].tag == prefetch_tag);

    always_comb begin
        mem_req.command = bus_none;
        mem_req.addr = prefetch_addr;
        if (any_demand) begin
            mem_req.command = bus_load;
            mem_req.addr = fetch_addr;
        end else if (prefetch_active && !prefetch_pending) begin
            mem_req.command = bus_load;
        end
    end

    assign accepted = (mem_req.command == bus_load) && (mem_rsp.response != '0);
    assign req_idx = mem_req.addr[`OFFSET_BITS +: `SET_BITS];
    assign req_tag = mem_req.addr[`TAG_LSB +: `TAG_BITS];

    // returning data looked up by completion tag
    assign fill.en = (mem_rsp.tag != '0) && wait_q[mem_rsp.tag].valid;
    assign fill.index = wait_q[mem_rsp.tag].index;
    assign fill.tag = wait_q[mem_rsp.tag].tag;

    always_comb begin
        prefetch_cnt_d = prefetch_cnt;
        if (any_demand) begin
            prefetch_cnt_d = CNT_BITS'(`PREFETCH_DEPTH); // rearm on every new miss
        end else if (prefetch_active) begin
            prefetch_cnt_d = prefetch_cnt - CNT_BITS'(1);
        end
    end

    always_comb begin
        prefetch_addr_d = prefetch_addr;
        if (accepted) begin
            prefetch_addr_d = mem_req.addr + `BLOCK_BYTES;
        end else if (!any_demand && prefetch_active && prefetch_pending) begin
            // already in flight, step past it
            prefetch_addr_d = prefetch_addr + `BLOCK_BYTES;
        end
    end

    // free on fill first, so a new load on the same edge takes over the entry
    always_comb begin
        wait_d = wait_q;
        pend_d = pend_q;
        if (fill.en) begin
            wait_d[mem_rsp.tag].valid = 1'b0;
            if (pend_q[fill.index].tag == fill.tag) begin
                pend_d[fill.index].valid = 1'b0; // keep a newer load to this set
            end
        end
        if (accepted) begin
            wait_d[mem_rsp.response] = '{valid: 1'b1, index: req_idx, tag: req_tag};
            pend_d[req_idx] = '{valid: 1'b1, tag: req_tag};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wait_q <= '0;
            pend_q <= '0;
            prefetch_cnt <= '0;
            prefetch_addr <= '0;
        end else begin
            wait_q <= wait_d;
            pend_q <= pend_d;
            prefetch_cnt <= prefetch_cnt_d;
            prefetch_addr <= prefetch_addr_d;
        end
    end

    // memory must not hand out a tag that is still outstanding
    // unless it completes in this very cycle
    assert property (@(posedge clock) disable iff (reset)
        accepted |-> (!wait_q[mem_rsp.response].valid
                      || (fill.en && (mem_rsp.tag == mem_rsp.response))))
        else $error("load accepted on a tag that is still waiting");

    // every completion must match an earlier accepted load
    assert property (@(posedge clock) disable iff (reset)
        (mem_rsp.tag != '0) |-> wait_q[mem_rsp.tag].valid)
        else $error("data returned on tag %0d with no wait entry", mem_rsp.tag);

endmodule

//--- source/icache_mem.sv
// icache tag and data arrays
`include "icache_consts.svh"

module icache_mem import icache_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  fetch_req_t [`WAYS-1:0]   fetch,
    input  fill_t                    fill,
    input  logic [`BLOCK_BITS-1:0]   fill_data,
    output fetch_rsp_t [`WAYS-1:0]   rsp,
    output logic       [`WAYS-1:0]   hit
);

    logic [`TAG_BITS-1:0]   tags   [`SETS];
    logic [`BLOCK_BITS-1:0] blocks [`SETS];
    logic [`SETS-1:0]       valid;

    // one combinational read port per fetch port
    for (genvar i = 0; i < `WAYS; i++) begin : g_read
        logic [`SET_BITS-1:0] idx;
        logic [`TAG_BITS-1:0] tag;

        assign idx = fetch[i].addr[`OFFSET_BITS +: `SET_BITS];
        assign tag = fetch[i].addr[`TAG_LSB +: `TAG_BITS];

        assign hit[i] = fetch[i].en && valid[idx] && (tags[idx] == tag);
        assign rsp[i].valid = hit[i];
        assign rsp[i].data = blocks[idx];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else if (fill.en) begin
            valid[fill.index] <= 1'b1;
        end
    end

    // fill overwrites whatever block held the set
    always_ff @(posedge clock) begin
        if (fill.en) begin
            tags[fill.index] <= fill.tag;
            blocks[fill.index] <= fill_data;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        fill.en |-> !$isunknown(fill.index))
        else $error("fill with unknown set index");

endmodule

//--- source/icache_pkg.sv
// icache bus and fill types
`include "icache_consts.svh"

package icache_pkg;

    // memory bus command, upper encodings reserved
    typedef enum logic [1:0] {
        bus_none = 2'd0,
        bus_load = 2'd1
    } bus_cmd_e;

    // one fetch port, processor to cache
    typedef struct packed {
        logic        en;
        logic [31:0] addr;
    } fetch_req_t;

    // one fetch port, cache to processor
    typedef struct packed {
        logic                   valid;
        logic [`BLOCK_BITS-1:0] data;
    } fetch_rsp_t;

    typedef struct packed {
        bus_cmd_e    command;
        logic [31:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic [`MEM_TAG_BITS-1:0] response; // accept tag, same cycle as the request
        logic [`MEM_TAG_BITS-1:0] tag;      // completion tag, nonzero with data
        logic [`BLOCK_BITS-1:0]   data;
    } mem_rsp_t;

    // write command into the tag and data arrays
    typedef struct packed {
        logic                 en;
        logic [`SET_BITS-1:0] index;
        logic [`TAG_BITS-1:0] tag;
    } fill_t;

    // outstanding load, one per memory tag
    typedef struct packed {
        logic                 valid;
        logic [`SET_BITS-1:0] index;
        logic [`TAG_BITS-1:0] tag;
    } wait_entry_t;

    // block in flight, one per set
    typedef struct packed {
        logic                 valid;
        logic [`TAG_BITS-1:0] tag;
    } pend_entry_t;

endpackage

//--- source/icache_top.sv
// non-blocking instruction cache top
`include "icache_consts.svh"

module icache_top import icache_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  fetch_req_t [`WAYS-1:0]   fetch,
    output fetch_rsp_t [`WAYS-1:0]   rsp,
    output mem_req_t                 mem_req,
    input  mem_rsp_t                 mem_rsp
);

    logic [`WAYS-1:0] hit;   // per port lookup result
    fill_t            fill;

    icache_ctrl ctrl0 (
        .clock   (clock),
        .reset   (reset),
        .fetch   (fetch),
        .hit     (hit),
        .mem_rsp (mem_rsp),
        .mem_req (mem_req),
        .fill    (fill)
    );

    // returned beat goes straight into the arrays
    icache_mem mem0 (
        .clock     (clock),
        .reset     (reset),
        .fetch     (fetch),
        .fill      (fill),
        .fill_data (mem_rsp.data),
        .rsp       (rsp),
        .hit       (hit)
    );

endmodule

//--- verif/icache_tb.sv
// icache directed testbench
`include "icache_consts.svh"

module icache_tb import icache_pkg::*; ();

    localparam int          CLOCK_PERIOD = 100;
    localparam logic [31:0] SEED = 32'h6f05_b846;
    localparam int          NUM_TESTS = 6;
    localparam int          TEST_CYCLES = 400;   // watchdog budget per test
    localparam int          WAIT_LIMIT = 100;
    localparam int          SETTLE_CYCLES = 20;  // latency plus a whole prefetch run

    logic                   clock;
    logic                   reset;
    logic                   refuse;
    fetch_req_t [`WAYS-1:0] fetch;
    fetch_rsp_t [`WAYS-1:0] rsp;
    mem_req_t               mem_req;
    mem_rsp_t               mem_rsp;

    int    load_count [8192];  // accepted loads per block of the 16-bit space
    string test_name;
    int    test_errors;
    int    errors;
    int    tests_run;
    int    tests_failed;

    icache_top dut0 (
        .clock   (clock),
        .reset   (reset),
        .fetch   (fetch),
        .rsp     (rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    imem_model #(.SEED(SEED)) mem0 (
        .clock   (clock),
        .reset   (reset),
        .refuse  (refuse),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // count every load the memory takes
    always @(posedge clock) begin
        if (!reset && mem_req.command == bus_load && mem_rsp.response != '0) begin
            load_count[mem_req.addr[15:3]] <= load_count[mem_req.addr[15:3]] + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [63:0] expected_block(input logic [31:0] addr);
        logic [31:0] lo;
        lo = xorshift32({addr[31:3], 3'b000} ^ SEED);
        return {xorshift32(lo), lo};
    endfunction

    function automatic int block_loads(input logic [31:0] addr);
        return load_count[addr[15:3]];
    endfunction

    function automatic logic [`WAYS-1:0] valid_bits();
        logic [`WAYS-1:0] v;
        for (int i = 0; i < `WAYS; i++) begin
            v[i] = rsp[i].valid;
        end
        return v;
    endfunction

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic close_test();
        tests_run++;
        errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, test_errors);
        end else begin
            $display("%s: ok", test_name);
        end
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("mismatch in %s, %s: expected %h, actual %h", test_name, what,
                 expected, actual);
        test_errors++;
    endtask

    // bounded wait for every port in the mask
    task automatic wait_valid(input logic [`WAYS-1:0] ports, output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            ok = ((valid_bits() & ports) == ports);
            cycles++;
        end
        if (!ok) begin
            $display("%s: no valid response within %0d cycles", test_name, WAIT_LIMIT);
            test_errors++;
        end
    endtask

    task automatic settle();
        @(posedge clock);
        fetch <= '0;
        repeat (SETTLE_CYCLES) @(posedge clock);
    endtask

    task automatic load_and_compare(input logic [31:0] addr);
        bit ok;
        @(posedge clock);
        fetch[0] <= '{en: 1'b1, addr: addr};
        wait_valid(`WAYS'(1), ok);
        if (ok && rsp[0].data != expected_block(addr)) begin
            report_mismatch($sformatf("data of %h", addr), expected_block(addr), rsp[0].data);
        end
        settle();
    endtask

    task automatic reset_state();
        start_test("reset_state");
        @(negedge clock);
        if (mem_req.command !== bus_none) begin
            report_mismatch("command", 64'(bus_none), 64'(mem_req.command));
        end
        // cold cache, enabled ports must still miss
        @(posedge clock);
        for (int i = 0; i < `WAYS; i++) begin
            fetch[i] <= '{en: 1'b1, addr: 32'(i * `BLOCK_BYTES)};
        end
        @(negedge clock);
        if (valid_bits() !== '0) begin
            report_mismatch("valid bits", 64'(0), 64'(valid_bits()));
        end
        settle();
        close_test();
    endtask

    task automatic cold_miss_then_hit();
        logic [31:0] addr;
        addr = 32'h0000_1240;
        start_test("cold_miss_then_hit");
        load_and_compare(addr);
        @(posedge clock);
        fetch[0] <= '{en: 1'b1, addr: addr + 32'd4};
        @(negedge clock);
        if (!rsp[0].valid) begin
            $display("%s: repeated request to a filled block was not valid", test_name);
            test_errors++;
        end else if (rsp[0].data != expected_block(addr)) begin
            report_mismatch("hit data", expected_block(addr), rsp[0].data);
        end
        settle();
        if (block_loads(addr) != 1) begin
            report_mismatch("loads of the block", 64'(1), 64'(block_loads(addr)));
        end
        close_test();
    endtask

    task automatic duplicate_miss();
        logic [31:0]      addr;
        logic [`WAYS-1:0] ports;
        bit               ok;
        addr = 32'h0000_2380;
        ports = '0;
        ports[0] = 1'b1;
        ports[`WAYS-1] = 1'b1;
        start_test("duplicate_miss");
        @(posedge clock);
        fetch[0] <= '{en: 1'b1, addr: addr};
        fetch[`WAYS-1] <= '{en: 1'b1, addr: addr + 32'd4};
        wait_valid(ports, ok);
        if (ok) begin
            if (rsp[0].data != expected_block(addr)) begin
                report_mismatch("port 0 data", expected_block(addr), rsp[0].data);
            end
            if (rsp[`WAYS-1].data != expected_block(addr)) begin
                report_mismatch("last port data", expected_block(addr), rsp[`WAYS-1].data);
            end
        end
        settle();
        if (block_loads(addr) != 1) begin
            report_mismatch("loads of the block", 64'(1), 64'(block_loads(addr)));
        end
        close_test();
    endtask

    task automatic sequential_prefetch();
        logic [31:0] base;
        logic [31:0] addr;
        base = 32'h0000_3400;
        start_test("sequential_prefetch");
        @(posedge clock);
        fetch[0] <= '{en: 1'b1, addr: base};
        settle();                         // one miss, then idle
        for (int k = 0; k <= `PREFETCH_DEPTH; k++) begin
            addr = base + 32'(k * `BLOCK_BYTES);
            if (block_loads(addr) != 1) begin
                report_mismatch($sformatf("loads of %h", addr), 64'(1), 64'(block_loads(addr)));
            end
        end
        // prefetch stops after the last block
        addr = base + 32'((`PREFETCH_DEPTH + 1) * `BLOCK_BYTES);
        if (block_loads(addr) != 0) begin
            report_mismatch($sformatf("loads of %h", addr), 64'(0), 64'(block_loads(addr)));
        end
        for (int k = 1; k <= `PREFETCH_DEPTH; k++) begin
            addr = base + 32'(k * `BLOCK_BYTES);
            @(posedge clock);
            fetch[0] <= '{en: 1'b1, addr: addr};
            @(negedge clock);
            if (!rsp[0].valid) begin
                $display("%s: prefetched block %h did not hit", test_name, addr);
                test_errors++;
            end else if (rsp[0].data != expected_block(addr)) begin
                report_mismatch($sformatf("data of %h", addr), expected_block(addr),
                                rsp[0].data);
            end
        end
        settle();
        // hits must not have caused new loads
        for (int k = 1; k <= `PREFETCH_DEPTH; k++) begin
            addr = base + 32'(k * `BLOCK_BYTES);
            if (block_loads(addr) != 1) begin
                report_mismatch($sformatf("loads of %h after hits", addr), 64'(1),
                                64'(block_loads(addr)));
            end
        end
        close_test();
    endtask

    task automatic memory_back_pressure();
        logic [31:0] base;
        logic [31:0] addr;
        bit          ok;
        base = 32'h0000_4500;
        start_test("memory_back_pressure");
        @(posedge clock);
        refuse <= 1'b1;
        fetch[0] <= '{en: 1'b1, addr: base};
        repeat (10) begin
            @(negedge clock);
            if (rsp[0].valid) begin
                $display("%s: data valid while the memory refused loads", test_name);
                test_errors++;
            end
            @(posedge clock);
        end
        refuse <= 1'b0;
        wait_valid(`WAYS'(1), ok);
        if (ok && rsp[0].data != expected_block(base)) begin
            report_mismatch("data after refusal", expected_block(base), rsp[0].data);
        end
        settle();
        if (block_loads(base) != 1) begin
            report_mismatch("loads of the block", 64'(1), 64'(block_loads(base)));
        end
        for (int k = 1; k <= `PREFETCH_DEPTH; k++) begin
            addr = base + 32'(k * `BLOCK_BYTES);
            if (block_loads(addr) > 1) begin
                $display("%s: block %h loaded %0d times", test_name, addr, block_loads(addr));
                test_errors++;
            end
        end
        close_test();
    endtask

    task automatic conflict_replacement();
        logic [31:0] first;
        logic [31:0] second;
        first = 32'h0000_5640;
        second = 32'h0000_6640;           // same set, other tag
        start_test("conflict_replacement");
        load_and_compare(first);
        load_and_compare(second);
        @(posedge clock);
        fetch[0] <= '{en: 1'b1, addr: first};
        @(negedge clock);
        if (rsp[0].valid) begin
            $display("%s: replaced block %h still hit", test_name, first);
            test_errors++;
        end
        load_and_compare(first);
        if (block_loads(first) != 2) begin
            report_mismatch("loads of the first block", 64'(2), 64'(block_loads(first)));
        end
        if (block_loads(second) != 1) begin
            report_mismatch("loads of the second block", 64'(1), 64'(block_loads(second)));
        end
        close_test();
    endtask

    initial begin
        clock = 1'b0;
        reset <= 1'b1;
        refuse <= 1'b0;
        fetch <= '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        reset_state();
        cold_miss_then_hit();
        duplicate_miss();
        sequential_prefetch();
        memory_back_pressure();
        conflict_replacement();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLOCK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", NUM_TESTS * TEST_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- verif/imem_model.sv
// tagged instruction memory model
`include "icache_consts.svh"

module imem_model import icache_pkg::*; #(
    parameter logic [31:0] SEED = 32'h0
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     refuse,    // turn away every load while high
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    // one load on its way back
    typedef struct packed {
        logic [`MEM_TAG_BITS-1:0] tag;
        logic [31:0]              addr;
    } flight_t;

    flight_t [`MEM_LATENCY-1:0] pipe;
    flight_t                    entry;
    flight_t                    done;
    logic [`MEM_TAGS-1:0]       busy;
    logic [`MEM_TAGS-1:0]       busy_d;
    logic [`MEM_TAG_BITS-1:0]   free_tag;
    logic                       accept;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // contents follow from the block address alone
    function automatic logic [63:0] block_word(input logic [31:0] addr);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = xorshift32({addr[31:3], 3'b000} ^ SEED);
        hi = xorshift32(lo);
        return {hi, lo};
    endfunction

    // lowest idle tag, 0 when all are out
    always_comb begin
        free_tag = '0;
        for (int t = `MEM_TAGS - 1; t > 0; t--) begin
            if (!busy[t]) begin
                free_tag = `MEM_TAG_BITS'(t);
            end
        end
    end

    assign accept = (mem_req.command == bus_load) && !refuse && (free_tag != '0);
    assign done = pipe[`MEM_LATENCY-1];

    always_comb begin
        entry = '0;
        if (accept) begin
            entry = '{tag: free_tag, addr: mem_req.addr};
        end
        busy_d = busy;
        if (done.tag != '0) begin
            busy_d[done.tag] = 1'b0;
        end
        if (accept) begin
            busy_d[free_tag] = 1'b1;
        end
    end

    assign mem_rsp.response = accept ? free_tag : '0;
    assign mem_rsp.tag = done.tag;
    assign mem_rsp.data = (done.tag != '0) ? block_word(done.addr) : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            pipe <= '0;
            busy <= '0;
        end else begin
            pipe <= {pipe[`MEM_LATENCY-2:0], entry}; // fixed latency shift
            busy <= busy_d;
        end
    end

endmodule
